//--- logic/gate_pkg.sv
/* shared widths and types for the packet buffer. fifo_depth must be at least 2;
   packets longer than fifo_depth words stall the input for good */
package gate_pkg;

    // payload width of one stream word
    localparam int word_width = 8;

    // number of words the FIFO can hold at once
    localparam int fifo_depth = 8;

    // a pointer only has to address fifo_depth entries
    localparam int addr_width = $clog2(fifo_depth);

    // counts run from zero up to fifo_depth inclusive, hence the extra value
    localparam int count_width = $clog2(fifo_depth + 1);

    // payload word as seen on every stream port
    typedef logic [word_width-1:0] word_t;

    // read or write position inside the FIFO storage
    typedef logic [addr_width-1:0] addr_t;

    // used both for FIFO occupancy and for the number of stored packets,
    // since neither can exceed fifo_depth
    typedef logic [count_width-1:0] count_t;

endpackage

//--- logic/pipeline_gate.sv
/* combinational gate on a ready/valid stream that holds no storage.
   enable must change synchronously to the clock of both sides */
`timescale 1ns/1ns

module pipeline_gate import gate_pkg::*; #(
    // when set, a closed gate also forces data and last to zero
    parameter bit gate_data = 1'b1
) (
    input  logic  enable,

    input  logic  up_valid,
    output logic  up_ready,
    input  word_t up_data,
    input  logic  up_last,

    output logic  down_valid,
    input  logic  down_ready,
    output word_t down_data,
    output logic  down_last
);

    // both directions of the handshake are masked together, otherwise one
    // side could see the other's signal and finish a transfer on its own
    assign down_valid = up_valid & enable;
    assign up_ready   = down_ready & enable;

    generate
        if (gate_data) begin : gen_gate_data
            // a closed gate shows an all-zero word so nothing stale leaks out
            assign down_data = enable ? up_data : '0;
            assign down_last = up_last & enable;
        end else begin : gen_pass_data
            // here only the handshake is gated and the payload always flows
            assign down_data = up_data;
            assign down_last = up_last;
        end
    endgenerate

endmodule

//--- logic/word_fifo.sv
/* synchronous FIFO of fifo_depth entries storing each word with its last flag.
   a word shows on out_* in the cycle after it is written */
`timescale 1ns/1ns

module word_fifo import gate_pkg::*; (
    input  logic  clock,
    input  logic  arst_n,

    input  logic  in_valid,
    output logic  in_ready,
    input  word_t in_data,
    input  logic  in_last,

    output logic  out_valid,
    input  logic  out_ready,
    output word_t out_data,
    output logic  out_last
);

    // payload words and their last flags sit in two parallel arrays
    word_t mem_data [fifo_depth];
    logic  mem_last [fifo_depth];

    addr_t  wr_ptr;
    addr_t  rd_ptr;
    count_t count;

    logic push;
    logic pop;

    // ready and valid depend only on the registered occupancy,
    // so there is no combinational path from one side to the other
    assign in_ready  = (count != count_t'(fifo_depth));
    assign out_valid = (count != '0);

    assign push = in_valid & in_ready;
    assign pop  = out_valid & out_ready;

    // head of the queue is read straight from storage
    assign out_data = mem_data[rd_ptr];
    assign out_last = mem_last[rd_ptr];

    // advance a pointer by one entry, wrapping at the end of storage.
    // the explicit wrap keeps this correct for depths that are not a power of two
    function automatic addr_t next_ptr(input addr_t ptr);
        addr_t result;
        if (ptr == addr_t'(fifo_depth - 1)) begin
            result = '0;
        end else begin
            result = ptr + addr_t'(1);
        end
        return result;
    endfunction

    // storage takes the word and its last flag at every accepted input
    always_ff @(posedge clock) begin
        if (push) begin
            mem_data[wr_ptr] <= in_data;
            mem_last[wr_ptr] <= in_last;
        end
    end

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            // a push and a pop in the same cycle leave the occupancy alone
            case ({push, pop})
                2'b10:   count <= count + count_t'(1);
                2'b01:   count <= count - count_t'(1);
                default: count <= count;
            endcase
        end
    end

endmodule

//--- logic/packet_counter.sv
/* counts complete packets held in the buffer and opens the gate while any exist.
   assumes no packet is longer than fifo_depth words */
`timescale 1ns/1ns

module packet_counter import gate_pkg::*; (
    input  logic clock,
    input  logic arst_n,

    // input side of the buffer, before the FIFO
    input  logic in_valid,
    input  logic in_ready,
    input  logic in_last,

    // output side of the buffer, after the gate
    input  logic out_valid,
    input  logic out_ready,
    input  logic out_last,

    output logic enable
);

    // each packet holds at least one word, so this never passes fifo_depth
    count_t packets;

    logic packet_in;
    logic packet_out;

    // a packet is complete once its last word has been accepted
    assign packet_in  = in_valid & in_ready & in_last;

    // and it is gone once its last word has been delivered
    assign packet_out = out_valid & out_ready & out_last;

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            packets <= '0;
        end else begin
            // one packet in and one out at the same edge cancel each other
            case ({packet_in, packet_out})
                2'b10:   packets <= packets + count_t'(1);
                2'b01:   packets <= packets - count_t'(1);
                default: packets <= packets;
            endcase
        end
    end

    // the gate opens as soon as one whole packet sits in the FIFO
    assign enable = (packets != '0);

endmodule

//--- logic/packet_buffer.sv
/* no word of a packet leaves this stream buffer before its last word is stored.
   packets longer than fifo_depth words deadlock the input */
`timescale 1ns/1ns

module packet_buffer import gate_pkg::*; (
    input  logic  clock,
    input  logic  arst_n,

    input  logic  in_valid,
    output logic  in_ready,
    input  word_t in_data,
    input  logic  in_last,

    output logic  out_valid,
    input  logic  out_ready,
    output word_t out_data,
    output logic  out_last
);

    // FIFO head as presented to the gate
    logic  fifo_valid;
    logic  fifo_ready;
    word_t fifo_data;
    logic  fifo_last;

    // high while at least one complete packet is stored
    logic  gate_enable;

    word_fifo u_fifo (
        .clock     (clock),
        .arst_n    (arst_n),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_data   (in_data),
        .in_last   (in_last),
        .out_valid (fifo_valid),
        .out_ready (fifo_ready),
        .out_data  (fifo_data),
        .out_last  (fifo_last)
    );

    // the counter sees the outer input handshake and the gated output,
    // so a packet only counts as gone once its last word really left
    packet_counter u_counter (
        .clock     (clock),
        .arst_n    (arst_n),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_last   (in_last),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_last  (out_last),
        .enable    (gate_enable)
    );

    // data is zeroed while closed so partial packets never show on the output
    pipeline_gate #(
        .gate_data (1'b1)
    ) u_gate (
        .enable     (gate_enable),
        .up_valid   (fifo_valid),
        .up_ready   (fifo_ready),
        .up_data    (fifo_data),
        .up_last    (fifo_last),
        .down_valid (out_valid),
        .down_ready (out_ready),
        .down_data  (out_data),
        .down_last  (out_last)
    );

endmodule

//--- verif/packet_buffer_tb.sv
/* random-stimulus testbench for packet_buffer against a queue model of the stream.
   inputs change on the falling clock edge and the model samples on the rising edge */
`timescale 1ns/1ns

module packet_buffer_tb import gate_pkg::*; ();

    localparam logic [31:0] seed = 32'h40e4b2f1;
    localparam int random_packets = 40;
    localparam int pressure_packets = 30;

    logic  clock;
    logic  arst_n;
    logic  in_valid;
    logic  in_ready;
    word_t in_data;
    logic  in_last;
    logic  out_valid;
    logic  out_ready;
    word_t out_data;
    logic  out_last;

    // each model entry keeps the last flag just above the payload bits
    logic [word_width:0] model_q [$];
    int          model_packets;
    int          accepted_words;
    int          pass_count;
    int          err_count;
    int          cycles;
    int          cycle_limit;
    logic [31:0] rng_state;
    // 0 always ready, 1 mostly ready, 2 random stretches, 3 never ready
    int          sink_mode;
    int          sink_hold;
    logic        sink_level;
    int          gap_range;
    int          packet_len [$];

    packet_buffer UUT (
        .clock     (clock),
        .arst_n    (arst_n),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_data   (in_data),
        .in_last   (in_last),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_data  (out_data),
        .out_last  (out_last)
    );

    always #20 clock = ~clock;

    function automatic logic [31:0] lcg_step(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    // the low bits of an LCG repeat quickly, so the draw uses the upper half
    function automatic int random_below(input int limit);
        rng_state = lcg_step(rng_state);
        return int'(rng_state[30:16]) % limit;
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("ERR %0t %s expected %0h actual %0h", $time, name, expected, actual);
            err_count++;
        end else begin
            pass_count++;
        end
    endtask

    task automatic drive_sink();
        case (sink_mode)
            0: out_ready = 1'b1;
            1: out_ready = (random_below(4) != 0);
            2: begin
                // hold one level for a random number of cycles
                if (sink_hold == 0) begin
                    sink_level = (random_below(2) == 1);
                    sink_hold  = random_below(8) + 1;
                end
                sink_hold--;
                out_ready = sink_level;
            end
            default: out_ready = 1'b0;
        endcase
    endtask

    task automatic set_sink(input int mode);
        sink_mode = mode;
        sink_hold = 0;
        drive_sink();
    endtask

    // every stimulus step ends just after a falling edge
    task automatic next_fall();
        @(negedge clock);
        drive_sink();
    endtask

    task automatic wait_accept();
        int target;
        target = accepted_words + 1;
        while (accepted_words < target) begin
            next_fall();
        end
    endtask

    task automatic send_packet(input int len);
        int i;
        int gap;
        for (i = 0; i < len; i++) begin
            gap = random_below(gap_range);
            while (gap > 0) begin
                in_valid = 1'b0;
                next_fall();
                gap--;
            end
            in_valid = 1'b1;
            in_data  = word_t'(random_below(1 << word_width));
            in_last  = (i == len - 1);
            wait_accept();
        end
        in_valid = 1'b0;
        in_last  = 1'b0;
    endtask

    task automatic drain();
        while (model_q.size() != 0) begin
            next_fall();
        end
    endtask

    task automatic report_test(input string name, input int errs_before);
        if (err_count == errs_before) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: failed with %0d errors", name, err_count - errs_before);
        end
    endtask

    // the model sees the values from before the edge, as the DUT registers do
    always @(posedge clock) begin : model_update
        logic [word_width:0] head;
        if (arst_n) begin
            check_value("in_ready", (model_q.size() != fifo_depth), in_ready);
            // no complete packet stored means a closed gate with zeroed payload
            if (model_packets == 0) begin
                check_value("out_valid", 0, out_valid);
                check_value("out_data", 0, out_data);
                check_value("out_last", 0, out_last);
            end
            if (out_valid && out_ready) begin
                if (model_q.size() == 0) begin
                    $display("error at %0t: a word left while the model holds none", $time);
                    err_count++;
                end else begin
                    head = model_q.pop_front();
                    check_value("out_data", head[word_width-1:0], out_data);
                    check_value("out_last", head[word_width], out_last);
                    if (head[word_width]) begin
                        model_packets--;
                    end
                end
            end
            if (in_valid && in_ready) begin
                model_q.push_back({in_last, in_data});
                accepted_words++;
                if (in_last) begin
                    model_packets++;
                end
            end
        end
    end

    initial begin : watchdog
        cycles = 0;
        @(posedge clock);
        while (cycles < cycle_limit) begin
            @(posedge clock);
            cycles++;
        end
        $display("timeout: the run did not finish within %0d clock cycles", cycle_limit);
        $display("TEST RESULT: FAIL");
        $finish;
    end

    initial begin : stimulus
        int total_words;
        int errs_before;
        int k;
        clock          = 1'b0;
        arst_n         = 1'b0;
        in_valid       = 1'b0;
        in_data        = '0;
        in_last        = 1'b0;
        out_ready      = 1'b0;
        rng_state      = seed;
        model_packets  = 0;
        accepted_words = 0;
        pass_count     = 0;
        err_count      = 0;
        sink_mode      = 3;
        sink_hold      = 0;
        sink_level     = 1'b0;
        gap_range      = 2;
        // nine words for the full FIFO test and one for early release
        total_words    = 10;
        // the lengths are drawn up front so the time limit is known from the start
        for (k = 0; k < random_packets + pressure_packets; k++) begin
            packet_len.push_back(random_below(fifo_depth) + 1);
            total_words += packet_len[k];
        end
        cycle_limit = total_words * 4 + 200;
        repeat (16) @(negedge clock);
        arst_n = 1'b1;

        errs_before = err_count;
        check_value("out_valid", 0, out_valid);
        check_value("in_ready", 1, in_ready);
        check_value("out_data", 0, out_data);
        check_value("out_last", 0, out_last);
        report_test("reset state", errs_before);

        errs_before = err_count;
        set_sink(1);
        for (k = 0; k < random_packets; k++) begin
            send_packet(packet_len[k]);
        end
        drain();
        report_test("random packets", errs_before);

        errs_before = err_count;
        set_sink(2);
        for (k = 0; k < pressure_packets; k++) begin
            send_packet(packet_len[random_packets + k]);
        end
        drain();
        report_test("back-pressure", errs_before);

        // eight words of three packets fill the FIFO while nothing drains
        errs_before = err_count;
        set_sink(3);
        gap_range = 1;
        send_packet(3);
        send_packet(3);
        send_packet(2);
        in_valid = 1'b1;
        in_data  = word_t'(random_below(1 << word_width));
        in_last  = 1'b1;
        repeat (4) next_fall();
        check_value("in_ready", 0, in_ready);
        check_value("fifo words", fifo_depth, model_q.size());
        set_sink(0);
        // one delivery frees a slot for the waiting word
        next_fall();
        check_value("in_ready", 1, in_ready);
        wait_accept();
        in_valid = 1'b0;
        in_last  = 1'b0;
        drain();
        report_test("full fifo", errs_before);

        errs_before = err_count;
        set_sink(0);
        send_packet(1);
        // the single word went into the empty buffer at the edge just passed
        // and the gate is already open for it
        check_value("out_valid", 1, out_valid);
        drain();
        report_test("early release", errs_before);

        $display("checks passed: %0d, errors: %0d", pass_count, err_count);
        if (err_count == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

//--- packet_buffer.f
logic/gate_pkg.sv
logic/pipeline_gate.sv
logic/word_fifo.sv
logic/packet_counter.sv
logic/packet_buffer.sv
verif/packet_buffer_tb.sv

//--- Bender.yml
package:
  name: packet_buffer

sources:
  # package first, then the blocks, then the top level
  - logic/gate_pkg.sv
  - logic/pipeline_gate.sv
  - logic/word_fifo.sv
  - logic/packet_counter.sv
  - logic/packet_buffer.sv

  - target: test
    files:
      - verif/packet_buffer_tb.sv
